// File: common/cpuPkg.sv
// cpu core types
// opcode, T-state and ALU enums plus the control, flag and bus structs
`include "cpu_consts.svh"

package cpuPkg;

  // decoded instruction, anything unknown falls to opNop
  typedef enum logic [`DATA_W-1:0] {
    opLdaImm = `OP_LDA_IMM,
    opLdxImm = `OP_LDX_IMM,
    opLdyImm = `OP_LDY_IMM,
    opAdcImm = `OP_ADC_IMM,
    opAndImm = `OP_AND_IMM,
    opOraImm = `OP_ORA_IMM,
    opEorImm = `OP_EOR_IMM,
    opTax = `OP_TAX,
    opTay = `OP_TAY,
    opInx = `OP_INX,
    opClc = `OP_CLC,
    opSec = `OP_SEC,
    opStaZp = `OP_STA_ZP,
    opJmpAbs = `OP_JMP_ABS,
    opNop = `OP_NOP
  } opcodeE;

  // cycle states of the sequencer
  typedef enum logic [1:0] {
    tFetch,
    tOperand,
    tOperandHigh,
    tWriteMem
  } tStateE;

  typedef enum logic [2:0] {
    aluPass,
    aluAdd,
    aluAnd,
    aluOr,
    aluEor,
    aluInc
  } aluOpE;

  // status bits kept by the core, order as in P
  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } flagsT;

  // per-cycle controls from the sequencer to the datapath
  typedef struct packed {
    aluOpE aluOp;
    logic aSelX;
    logic bSelA;
    logic loadA;
    logic loadX;
    logic loadY;
    logic loadFlags;
    logic carrySet;
    logic carryClear;
    logic writeMem;
    logic loadPcFromBus;
    logic incPc;
  } ctrlT;

  // external bus request
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] dataOut;
    logic rw;
  } busT;

endpackage

// File: common/cpu_consts.svh
// cpu core constants
// bus widths, reset address and opcode byte encodings
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_W 8
`define ADDR_W 16

// first opcode fetch after reset, no vector fetch
`define RESET_PC 16'h0200

// standard 6502 encodings of the kept opcodes
`define OP_LDA_IMM 8'hA9
`define OP_LDX_IMM 8'hA2
`define OP_LDY_IMM 8'hA0
`define OP_ADC_IMM 8'h69
`define OP_AND_IMM 8'h29
`define OP_ORA_IMM 8'h09
`define OP_EOR_IMM 8'h49
`define OP_TAX 8'hAA
`define OP_TAY 8'hA8
`define OP_INX 8'hE8
`define OP_CLC 8'h18
`define OP_SEC 8'h38
`define OP_STA_ZP 8'h85
`define OP_JMP_ABS 8'h4C
`define OP_NOP 8'hEA

`endif

// File: control/timingFsm.sv
// T-state sequencer
// instruction and operand registers, opcode decode and per-cycle controls
`timescale 1ns/1ps
`include "cpu_consts.svh"

module timingFsm import cpuPkg::*; (
  input  logic               phi0,
  input  logic               rstN,
  input  logic               rdy,
  input  logic [`DATA_W-1:0] dataIn,
  output ctrlT               ctrl,
  output logic [`DATA_W-1:0] operand,
  output logic               sync
);

  tStateE state;
  tStateE nextState;
  logic [`DATA_W-1:0] ir;
  opcodeE opcode;

  // opcode byte to instruction, unknown bytes act as NOP
  always_comb begin
    case (ir)
      `OP_LDA_IMM: opcode = opLdaImm;
      `OP_LDX_IMM: opcode = opLdxImm;
      `OP_LDY_IMM: opcode = opLdyImm;
      `OP_ADC_IMM: opcode = opAdcImm;
      `OP_AND_IMM: opcode = opAndImm;
      `OP_ORA_IMM: opcode = opOraImm;
      `OP_EOR_IMM: opcode = opEorImm;
      `OP_TAX: opcode = opTax;
      `OP_TAY: opcode = opTay;
      `OP_INX: opcode = opInx;
      `OP_CLC: opcode = opClc;
      `OP_SEC: opcode = opSec;
      `OP_STA_ZP: opcode = opStaZp;
      `OP_JMP_ABS: opcode = opJmpAbs;
      default: opcode = opNop;
    endcase
  end

  // controls for the current cycle and the step to the next state
  always_comb begin
    ctrl = '0;
    ctrl.aluOp = aluPass;
    nextState = state;
    case (state)
      tFetch: begin
        // opcode read, step past it
        ctrl.incPc = 1'b1;
        nextState = tOperand;
      end
      tOperand: begin
        nextState = tFetch;
        case (opcode)
          opLdaImm, opAdcImm, opAndImm, opOraImm, opEorImm: begin
            ctrl.loadA = 1'b1;
            ctrl.loadFlags = 1'b1;
            ctrl.incPc = 1'b1;
          end
          opLdxImm: begin
            ctrl.loadX = 1'b1;
            ctrl.loadFlags = 1'b1;
            ctrl.incPc = 1'b1;
          end
          opLdyImm: begin
            ctrl.loadY = 1'b1;
            ctrl.loadFlags = 1'b1;
            ctrl.incPc = 1'b1;
          end
          // transfers route A through the b side
          opTax: begin
            ctrl.bSelA = 1'b1;
            ctrl.loadX = 1'b1;
            ctrl.loadFlags = 1'b1;
          end
          opTay: begin
            ctrl.bSelA = 1'b1;
            ctrl.loadY = 1'b1;
            ctrl.loadFlags = 1'b1;
          end
          opInx: begin
            ctrl.aluOp = aluInc;
            ctrl.aSelX = 1'b1;
            ctrl.loadX = 1'b1;
            ctrl.loadFlags = 1'b1;
          end
          opClc: ctrl.carryClear = 1'b1;
          opSec: ctrl.carrySet = 1'b1;
          // zp address byte captured in operand, store follows
          opStaZp: begin
            ctrl.incPc = 1'b1;
            nextState = tWriteMem;
          end
          // low target byte captured, high byte next
          opJmpAbs: begin
            ctrl.incPc = 1'b1;
            nextState = tOperandHigh;
          end
          default: begin
            // dummy read of the next byte, PC stays
            nextState = tFetch;
          end
        endcase
        // ALU op for the immediate group
        case (opcode)
          opAdcImm: ctrl.aluOp = aluAdd;
          opAndImm: ctrl.aluOp = aluAnd;
          opOraImm: ctrl.aluOp = aluOr;
          opEorImm: ctrl.aluOp = aluEor;
          default: ;
        endcase
      end
      tOperandHigh: begin
        ctrl.loadPcFromBus = 1'b1;
        nextState = tFetch;
      end
      tWriteMem: begin
        ctrl.writeMem = 1'b1;
        nextState = tFetch;
      end
      default: nextState = tFetch;
    endcase
  end

  // state and IR advance only on completing edges
  always_ff @(posedge phi0 or negedge rstN) begin
    if (!rstN) begin
      state <= tFetch;
      ir <= `OP_NOP;
    end else if (rdy) begin
      state <= nextState;
      if (state == tFetch) begin
        ir <= dataIn;
      end
    end
  end

  // second instruction byte, zp address or low jump target
  always_ff @(posedge phi0) begin
    if (rdy && state == tOperand) begin
      operand <= dataIn;
    end
  end

  assign sync = (state == tFetch);

  // store cycle entered only straight from the STA operand read
  assert property (@(posedge phi0) disable iff (!rstN)
    $rose(state == tWriteMem) |-> $past(state == tOperand && opcode == opStaZp && rdy))
    else $error("write cycle not preceded by STA operand");

  // one completing fetch, then the operand read
  assert property (@(posedge phi0) disable iff (!rstN)
    (sync && rdy) |=> (!sync && state == tOperand))
    else $error("sync outside a single fetch cycle");

endmodule

// File: cpu6502Top.f
+incdir+common
common/cpuPkg.sv
control/timingFsm.sv
datapath/programCounter.sv
datapath/registerFile.sv
datapath/alu.sv
design/cpu6502Top.sv
tb/tbClock.sv
tb/cpu6502Tb.sv

// File: datapath/alu.sv
// combinational ALU
// binary add with carry, logic ops, increment and pass, with N/V/Z/C results
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu import cpuPkg::*; (
  input  aluOpE              op,
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  logic               carryIn,
  output logic [`DATA_W-1:0] result,
  output flagsT              flagsOut
);

  logic [`DATA_W:0] sum;
  logic carryOut;
  logic overflow;

  // one extra bit for the carry out
  assign sum = {1'b0, a} + {1'b0, b} + {{`DATA_W{1'b0}}, carryIn};

  always_comb begin
    result = b;
    // non-add ops hand C back unchanged
    carryOut = carryIn;
    // V only meaningful on add
    overflow = 1'b0;
    case (op)
      aluPass: result = b;
      aluAdd: begin
        result = sum[`DATA_W-1:0];
        carryOut = sum[`DATA_W];
        // same-sign inputs, result sign flipped
        overflow = (a[`DATA_W-1] == b[`DATA_W-1]) &&
                   (sum[`DATA_W-1] != a[`DATA_W-1]);
      end
      aluAnd: result = a & b;
      aluOr: result = a | b;
      aluEor: result = a ^ b;
      aluInc: result = a + {{(`DATA_W-1){1'b0}}, 1'b1};
      default: result = b;
    endcase
  end

  always_comb begin
    flagsOut.n = result[`DATA_W-1];
    flagsOut.v = overflow;
    flagsOut.z = (result == '0);
    flagsOut.c = carryOut;
  end

endmodule

// File: datapath/programCounter.sv
// program counter with incrementer
// drives the address bus from the PC or the zero-page operand
`timescale 1ns/1ps
`include "cpu_consts.svh"

module programCounter import cpuPkg::*; (
  input  logic               phi0,
  input  logic               rstN,
  input  logic               rdy,
  input  ctrlT               ctrl,
  input  logic [`DATA_W-1:0] operand,
  input  logic [`DATA_W-1:0] dataIn,
  output logic [`ADDR_W-1:0] addr
);

  logic [`ADDR_W-1:0] pc;
  logic [`ADDR_W-1:0] pcNext;

  // plain +1, wraps at the top of memory
  assign pcNext = pc + {{(`ADDR_W-1){1'b0}}, 1'b1};

  always_ff @(posedge phi0 or negedge rstN) begin
    if (!rstN) begin
      pc <= `RESET_PC;
    end else if (rdy) begin
      // jump target, high byte on the bus, low byte held
      if (ctrl.loadPcFromBus) begin
        pc <= {dataIn, operand};
      end else if (ctrl.incPc) begin
        pc <= pcNext;
      end
    end
  end

  // store cycle addresses page zero
  assign addr = ctrl.writeMem ? {{(`ADDR_W-`DATA_W){1'b0}}, operand} : pc;

  // operand must be loaded before any store uses it
  assert property (@(posedge phi0) disable iff (!rstN) !$isunknown(addr))
    else $error("address bus unknown");

endmodule

// File: datapath/registerFile.sv
// A, X and Y registers with N/V/Z/C status
// picks ALU operands, writes results back and presents A for stores
`timescale 1ns/1ps
`include "cpu_consts.svh"

module registerFile import cpuPkg::*; (
  input  logic               phi0,
  input  logic               rstN,
  input  logic               rdy,
  input  ctrlT               ctrl,
  input  logic [`DATA_W-1:0] dataIn,
  input  logic [`DATA_W-1:0] aluResult,
  input  flagsT              aluFlags,
  output logic [`DATA_W-1:0] aluA,
  output logic [`DATA_W-1:0] aluB,
  output logic [`DATA_W-1:0] dataOut,
  output logic [`DATA_W-1:0] accum,
  output logic [`DATA_W-1:0] xReg,
  output logic [`DATA_W-1:0] yReg,
  output flagsT              flags
);

  // X for INX, A otherwise
  assign aluA = ctrl.aSelX ? xReg : accum;
  // A for transfers, immediate byte otherwise
  assign aluB = ctrl.bSelA ? accum : dataIn;
  // A doubles as the data-out register
  assign dataOut = accum;

  always_ff @(posedge phi0 or negedge rstN) begin
    if (!rstN) begin
      accum <= '0;
      xReg <= '0;
      yReg <= '0;
      flags <= '0;
    end else if (rdy) begin
      if (ctrl.loadA) accum <= aluResult;
      if (ctrl.loadX) xReg <= aluResult;
      if (ctrl.loadY) yReg <= aluResult;
      if (ctrl.loadFlags) begin
        flags.n <= aluFlags.n;
        flags.z <= aluFlags.z;
        // C and V only from ADC
        if (ctrl.aluOp == aluAdd) begin
          flags.c <= aluFlags.c;
          flags.v <= aluFlags.v;
        end
      end
      // CLC / SEC
      if (ctrl.carrySet) begin
        flags.c <= 1'b1;
      end else if (ctrl.carryClear) begin
        flags.c <= 1'b0;
      end
    end
  end

  // N and Z follow the register that was written
  assert property (@(posedge phi0) disable iff (!rstN)
    ctrl.loadFlags |-> (ctrl.loadA || ctrl.loadX || ctrl.loadY))
    else $error("flags loaded without a register write");

endmodule

// File: design/cpu6502Top.sv
// 6502-style cpu core top level
// joins the T-state sequencer with the PC, register file and ALU datapath
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu6502Top import cpuPkg::*; (
  input  logic               phi0,
  input  logic               rstN,
  input  logic               rdy,
  input  logic [`DATA_W-1:0] dataIn,
  output busT                bus,
  output logic               sync,
  output logic [`DATA_W-1:0] accum,
  output logic [`DATA_W-1:0] xReg,
  output logic [`DATA_W-1:0] yReg,
  output flagsT              flags
);

  ctrlT ctrl;
  logic [`DATA_W-1:0] operand;
  logic [`ADDR_W-1:0] addr;
  logic [`DATA_W-1:0] aluA;
  logic [`DATA_W-1:0] aluB;
  logic [`DATA_W-1:0] aluResult;
  logic [`DATA_W-1:0] dataOut;
  flagsT aluFlags;

  // control side
  timingFsm uFsm (
    .phi0(phi0), .rstN(rstN), .rdy(rdy), .dataIn(dataIn),
    .ctrl(ctrl), .operand(operand), .sync(sync)
  );

  // address generation
  programCounter uPc (
    .phi0(phi0), .rstN(rstN), .rdy(rdy), .ctrl(ctrl),
    .operand(operand), .dataIn(dataIn), .addr(addr)
  );

  registerFile uRegs (
    .phi0(phi0), .rstN(rstN), .rdy(rdy), .ctrl(ctrl), .dataIn(dataIn),
    .aluResult(aluResult), .aluFlags(aluFlags),
    .aluA(aluA), .aluB(aluB), .dataOut(dataOut),
    .accum(accum), .xReg(xReg), .yReg(yReg), .flags(flags)
  );

  // carry in always comes from the live C flag
  alu uAlu (
    .op(ctrl.aluOp), .a(aluA), .b(aluB), .carryIn(flags.c),
    .result(aluResult), .flagsOut(aluFlags)
  );

  // bus request
  // rw low only in the store cycle
  assign bus.addr = addr;
  assign bus.dataOut = dataOut;
  assign bus.rw = ~ctrl.writeMem;

endmodule

// File: run.sh
#!/bin/sh
# compile the core and its testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu6502Tb -f cpu6502Top.f -o simv

out=$(./obj_dir/simv 2>&1) || true
printf '%s\n' "$out"

# pass only when the testbench reported success
printf '%s\n' "$out" | grep -qx "Test passed"

// File: tb/cpu6502Tb.sv
// testbench for the 6502-style core
// memory model, random RDY stalls, instruction-level reference model and checker
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu6502Tb import cpuPkg::*; ();

  localparam int maxStalls = 60;

  logic phi0;
  logic rstN;
  logic rdy;
  logic [`DATA_W-1:0] dataIn;
  busT bus;
  logic sync;
  logic [`DATA_W-1:0] accum;
  logic [`DATA_W-1:0] xReg;
  logic [`DATA_W-1:0] yReg;
  flagsT flags;

  // DUT memory and the model's copy
  logic [7:0] mem [0:65535];
  logic [7:0] refMem [0:65535];
  logic [7:0] opTable [0:15];
  logic [15:0] lfsr;
  logic [15:0] asmPc;
  logic built;
  logic done;
  int instrCount;
  int stalls;

  // reference model state
  logic [7:0] mA;
  logic [7:0] mX;
  logic [7:0] mY;
  flagsT mF;
  logic [15:0] mPc;
  logic storePending;
  logic [7:0] storeAddr;
  logic [7:0] storeData;
  int expLen;
  int cycles;
  int completed;
  int loopHits;

  tbClock uClk (.clk(phi0), .rstN(rstN));

  cpu6502Top i_dut (
    .phi0(phi0), .rstN(rstN), .rdy(rdy), .dataIn(dataIn),
    .bus(bus), .sync(sync), .accum(accum), .xReg(xReg), .yReg(yReg), .flags(flags)
  );

  // asynchronous read, write on a completing edge
  assign dataIn = mem[bus.addr];

  always @(posedge phi0) begin
    if (rstN && rdy && !bus.rw) begin
      mem[bus.addr] <= bus.dataOut;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [7:0] takeBits(input int n);
    logic [7:0] v;
    logic fb;
    v = 8'h00;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[6:0], fb};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic emit(input logic [7:0] b);
    mem[asmPc] = b;
    refMem[asmPc] = b;
    asmPc = asmPc + 16'd1;
  endtask

  // immediates and STA carry one operand byte
  task automatic emitInstr(input logic [7:0] op, input logic [7:0] opd);
    emit(op);
    case (op)
      `OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM, `OP_ADC_IMM, `OP_AND_IMM,
      `OP_ORA_IMM, `OP_EOR_IMM, `OP_STA_ZP: emit(opd);
      default: ;
    endcase
    instrCount++;
  endtask

  task automatic emitJmp(input logic [15:0] target);
    emit(`OP_JMP_ABS);
    emit(target[7:0]);
    emit(target[15:8]);
    instrCount++;
  endtask

  function automatic void setNz(input logic [7:0] v);
    mF.n = v[7];
    mF.z = (v == 8'h00);
  endfunction

  // one whole instruction of the reference model
  function automatic void stepModel();
    logic [7:0] op;
    logic [7:0] opd;
    logic [8:0] sum;
    op = refMem[mPc];
    opd = refMem[mPc + 16'd1];
    expLen = 2;
    case (op)
      `OP_LDA_IMM: mA = opd;
      `OP_LDX_IMM: mX = opd;
      `OP_LDY_IMM: mY = opd;
      `OP_AND_IMM: mA = mA & opd;
      `OP_ORA_IMM: mA = mA | opd;
      `OP_EOR_IMM: mA = mA ^ opd;
      `OP_ADC_IMM: begin
        sum = {1'b0, mA} + {1'b0, opd} + {8'h00, mF.c};
        // signed overflow when both inputs agree in sign and the sum does not
        mF.v = (mA[7] ~^ opd[7]) & (mA[7] ^ sum[7]);
        mF.c = sum[8];
        mA = sum[7:0];
      end
      `OP_TAX: mX = mA;
      `OP_TAY: mY = mA;
      `OP_INX: mX = mX + 8'd1;
      `OP_CLC: mF.c = 1'b0;
      `OP_SEC: mF.c = 1'b1;
      `OP_STA_ZP: begin
        storePending = 1'b1;
        storeAddr = opd;
        storeData = mA;
        refMem[{8'h00, opd}] = mA;
        expLen = 3;
      end
      `OP_JMP_ABS: expLen = 3;
      default: ;
    endcase
    // N and Z from the written register
    case (op)
      `OP_LDA_IMM, `OP_ADC_IMM, `OP_AND_IMM, `OP_ORA_IMM, `OP_EOR_IMM, `OP_TAY: setNz(mA);
      `OP_LDX_IMM, `OP_TAX, `OP_INX: setNz(mX);
      `OP_LDY_IMM: setNz(mY);
      default: ;
    endcase
    case (op)
      `OP_JMP_ABS: begin
        if ({refMem[mPc + 16'd2], opd} == mPc) begin
          loopHits++;
        end
        mPc = {refMem[mPc + 16'd2], opd};
      end
      `OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM, `OP_ADC_IMM, `OP_AND_IMM,
      `OP_ORA_IMM, `OP_EOR_IMM, `OP_STA_ZP: mPc = mPc + 16'd2;
      default: mPc = mPc + 16'd1;
    endcase
  endfunction

  // program image and model reset state
  initial begin
    logic [7:0] op;
    logic [7:0] opd;
    logic [15:0] loopAddr;
    built = 1'b0;
    done = 1'b0;
    lfsr = 16'd31787;
    instrCount = 0;
    storePending = 1'b0;
    loopHits = 0;
    completed = 0;
    cycles = 0;
    mA = 8'h00;
    mX = 8'h00;
    mY = 8'h00;
    mF = '0;
    mPc = `RESET_PC;
    for (int i = 0; i < 65536; i++) begin
      mem[16'(i)] = 8'(i) ^ 8'(i >> 8);
      refMem[16'(i)] = 8'(i) ^ 8'(i >> 8);
    end
    // 0xFF is not a kept opcode
    opTable = '{`OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM, `OP_ADC_IMM, `OP_AND_IMM,
                `OP_ORA_IMM, `OP_EOR_IMM, `OP_TAX, `OP_TAY, `OP_INX, `OP_CLC,
                `OP_SEC, `OP_STA_ZP, `OP_NOP, 8'hFF, `OP_ADC_IMM};
    asmPc = `RESET_PC;
    // overflow, carry out and carry in cases
    emitInstr(`OP_CLC, 8'h00);
    emitInstr(`OP_LDA_IMM, 8'h7F);
    emitInstr(`OP_ADC_IMM, 8'h01);
    emitInstr(`OP_SEC, 8'h00);
    emitInstr(`OP_LDA_IMM, 8'hFF);
    emitInstr(`OP_ADC_IMM, 8'h00);
    emitInstr(`OP_LDA_IMM, 8'h80);
    emitInstr(`OP_CLC, 8'h00);
    emitInstr(`OP_ADC_IMM, 8'h80);
    emitInstr(`OP_STA_ZP, 8'h10);
    emitInstr(`OP_LDX_IMM, 8'hFF);
    emitInstr(`OP_INX, 8'h00);
    for (int i = 0; i < 48; i++) begin
      if (i == 24) begin
        // jump over the gap to the second block
        emitJmp(16'h0300);
        asmPc = 16'h0300;
      end
      op = opTable[4'(takeBits(4))];
      opd = takeBits(8);
      emitInstr(op, opd);
    end
    loopAddr = asmPc;
    emitJmp(loopAddr);
    built = 1'b1;
  end

  // rdy changes just after the edge
  initial begin
    logic [7:0] draw;
    rdy = 1'b1;
    stalls = 0;
    wait (built);
    forever begin
      @(posedge phi0);
      #1;
      draw = takeBits(2);
      if (rstN && stalls < maxStalls && draw == 8'h00) begin
        rdy = 1'b0;
        stalls++;
      end else begin
        rdy = 1'b1;
      end
    end
  end

  // completing cycles sampled mid-cycle, away from the rising edge
  always @(negedge phi0) begin
    if (rstN && rdy && built && !done) begin
      if (completed == 0) begin
        check("sync after reset", 16'd1, 16'(sync));
      end
      if (sync) begin
        if (completed != 0) begin
          check("instruction length", 16'(expLen), 16'(cycles));
        end
        check("store done", 16'd0, 16'(storePending));
        check("read during fetch", 16'd1, 16'(bus.rw));
        check("fetch address", mPc, bus.addr);
        check("accumulator", 16'(mA), 16'(accum));
        check("x register", 16'(mX), 16'(xReg));
        check("y register", 16'(mY), 16'(yReg));
        check("flags", 16'(mF), 16'(flags));
        if (loopHits >= 3) begin
          done = 1'b1;
        end else begin
          stepModel();
        end
        cycles = 1;
      end else begin
        if (!bus.rw) begin
          check("unexpected write", 16'd1, 16'(storePending));
          check("store address", {8'h00, storeAddr}, bus.addr);
          check("store data", 16'(storeData), 16'(bus.dataOut));
          storePending = 1'b0;
        end
        cycles++;
      end
      completed++;
    end
  end

  // three cycles per instruction at most, plus stalls and reset
  initial begin
    wait (built);
    repeat ((instrCount + 3) * 3 + maxStalls + 10) @(posedge phi0);
    $display("timeout: the program did not reach its final loop in time");
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    wait (done);
    for (int i = 0; i < 256; i++) begin
      check("zero page", 16'(refMem[16'(i)]), 16'(mem[16'(i)]));
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: tb/tbClock.sv
// testbench clock and reset source
// free-running clock, reset held low for a fixed number of cycles
`timescale 1ns/1ps

module tbClock #(
  parameter int period = 20,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release just after an edge, like the other inputs
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule
